// File: flist.f
+incdir+include
src/dmmu_pkg.sv
src/tlb_lookup_if.sv
src/dmmu_req_stage.sv
src/dtlb_way.sv
src/dmmu_resolve.sv
src/dmmu_top.sv
verif/tb_dmmu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the data MMU simulation with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_dmmu_top \
   -Mdir obj_dir -o sim_dmmu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_dmmu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The log decides the result
if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi
exit 0

// File: verif/tb_dmmu_top.sv
// Data MMU testbench
`timescale 1ns/1ns
`include "dmmu_consts.svh"

module tb_dmmu_top
   import dmmu_pkg::*;
();

   localparam int VPN_DW = `DMMU_VPN_DW;
   localparam int SET_AW = `DMMU_SET_AW;
   localparam int WAY_AW = `DMMU_WAY_AW;
   localparam int TAG_HI = VPN_DW - SET_AW;
   localparam int WAYS   = `DMMU_WAYS;
   localparam int SETS   = 1 << SET_AW;
   // Rough cycles per test, two per write and three per lookup
   localparam int TEST_CYCLES = 10 + 60 + 60 + 17 + 226 + 178 + 664;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   logic clk = 1'b0;
   logic reset, re, we, dmme;
   logic [VPN_DW-1:0] vpn;
   priv_mode_e mode;
   msr_op_e tlb_op;
   logic [WAY_AW+SET_AW-1:0] tlb_idx;
   logic [`DMMU_DW-1:0] tlb_wdat;
   logic [VPN_DW-1:0] ppn;
   logic edtm, edpf, uncached;

   // Shadow copy of both ways
   tlb_lo_t lo_sh [WAYS][SETS];
   tlb_hi_t hi_sh [WAYS][SETS];
   int errors = 0;
   int checks = 0;
   int cycles = 0;

   always #2 clk = ~clk;

   dmmu_top DUT (.*);

   // Run limit
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   function automatic tlb_lo_t lo_entry(input logic [VPN_DW-1:0] tag, input logic v);
      tlb_lo_t e;
      e = '0;
      e.vpn = tag;
      e.v = v;
      return e;
   endfunction

   // attr is {unc, rr, rw, ur, uw}
   function automatic tlb_hi_t hi_entry(input logic [VPN_DW-1:0] p, input logic [4:0] attr);
      tlb_hi_t e;
      e = '0;
      e.ppn = p;
      {e.unc, e.rr, e.rw, e.ur, e.uw} = attr;
      return e;
   endfunction

   // Resolve rules applied to the shadow, packed as {ppn, edtm, edpf, uncached}
   function automatic logic [VPN_DW+2:0] expected_result(input logic [VPN_DW-1:0] v,
      input logic st, input priv_mode_e m, input logic en);
      logic [SET_AW-1:0] s;
      logic hit, perm, x_tm, x_pf, unc;
      tlb_hi_t hw;
      logic [VPN_DW-1:0] p;
      s = v[SET_AW-1:0];
      hit = 1'b0;
      hw = '0;
      for (int w = 0; w < WAYS; w++)
      begin
         if (lo_sh[w][s].v && lo_sh[w][s].vpn == v)
         begin
            hit = 1'b1;
            hw = hi_sh[w][s];
         end
      end
      if (m == MODE_ROOT)
         perm = st ? hw.rw : hw.rr;
      else
         perm = st ? hw.uw : hw.ur;
      x_tm = en && !hit;
      x_pf = en && hit && !perm;
      // Identity map when off, nothing selected on a miss
      p = !en ? v : (hit ? hw.ppn : '0);
      unc = en && hit && perm && hw.unc;
      if ((`DMMU_UNC_SEG == 1) && !x_tm && !x_pf && !p[VPN_DW-1])
         unc = 1'b1;
      return {p, x_tm, x_pf, unc};
   endfunction

   task automatic compare_outputs(input logic [VPN_DW+2:0] exp);
      logic [VPN_DW-1:0] e_ppn;
      logic e_tm, e_pf, e_unc;
      {e_ppn, e_tm, e_pf, e_unc} = exp;
      checks += 4;
      assert (ppn === e_ppn) else begin
         errors++;
         $display("FAIL %0t ppn got %h expected %h", $time, ppn, e_ppn);
      end
      assert (edtm === e_tm) else begin
         errors++;
         $display("FAIL %0t edtm got %b expected %b", $time, edtm, e_tm);
      end
      assert (edpf === e_pf) else begin
         errors++;
         $display("FAIL %0t edpf got %b expected %b", $time, edpf, e_pf);
      end
      assert (uncached === e_unc) else begin
         errors++;
         $display("FAIL %0t uncached got %b expected %b", $time, uncached, e_unc);
      end
   endtask

   // One strobe cycle, lookup and write may share the edge
   task automatic drive_cycle(input logic rd, input logic [VPN_DW-1:0] v, input logic st,
      input priv_mode_e m, input logic en, input msr_op_e op,
      input logic [WAY_AW+SET_AW-1:0] idx, input logic [`DMMU_DW-1:0] data);
      logic [VPN_DW+2:0] exp;
      logic [WAY_AW-1:0] w;
      logic [SET_AW-1:0] s;
      // Taken before the write lands, same-edge lookup sees the old entry
      exp = expected_result(v, st, m, en);
      @(posedge clk);
      re <= rd;
      vpn <= v;
      we <= st;
      mode <= m;
      dmme <= en;
      tlb_op <= op;
      tlb_idx <= idx;
      tlb_wdat <= data;
      @(posedge clk);
      re <= 1'b0;
      tlb_op <= OP_NONE;
      {w, s} = idx;
      if (op == OP_WR_LO)
         lo_sh[w][s] = tlb_lo_t'(data);
      else if (op == OP_WR_HI)
         hi_sh[w][s] = tlb_hi_t'(data);
      if (rd)
      begin
         // Mid-cycle, one edge after the strobe
         @(negedge clk);
         compare_outputs(exp);
      end
   endtask

   task automatic write_word(input msr_op_e op, input int way, input int set,
      input logic [`DMMU_DW-1:0] data);
      drive_cycle(1'b0, '0, 1'b0, MODE_USER, 1'b0, op, {WAY_AW'(way), SET_AW'(set)}, data);
   endtask

   task automatic lookup(input logic [VPN_DW-1:0] v, input logic st, input priv_mode_e m,
      input logic en);
      drive_cycle(1'b1, v, st, m, en, OP_NONE, '0, '0);
   endtask

   task automatic identity_when_disabled();
      repeat (20)
         lookup(VPN_DW'($urandom), 1'($urandom), priv_mode_e'(1'($urandom)), 1'b0);
   endtask

   // Reset left every entry invalid
   task automatic empty_tlb_misses();
      repeat (20)
         lookup(VPN_DW'($urandom), 1'($urandom), priv_mode_e'(1'($urandom)), 1'b1);
   endtask

   task automatic two_way_hits();
      logic [VPN_DW-1:0] tag_a, tag_b;
      tag_a = {TAG_HI'(15'h0a1c), SET_AW'(5)};
      tag_b = {TAG_HI'(15'h3301), SET_AW'(5)};
      write_word(OP_WR_LO, 0, 5, lo_entry(tag_a, 1'b1));
      write_word(OP_WR_HI, 0, 5, hi_entry(VPN_DW'($urandom), 5'b01111));
      write_word(OP_WR_LO, 1, 5, lo_entry(tag_b, 1'b1));
      write_word(OP_WR_HI, 1, 5, hi_entry(VPN_DW'($urandom), 5'b01111));
      lookup(tag_a, 1'b0, MODE_ROOT, 1'b1);
      lookup(tag_b, 1'b1, MODE_USER, 1'b1);
      // Third tag in the same set
      lookup({TAG_HI'(15'h0077), SET_AW'(5)}, 1'b0, MODE_ROOT, 1'b1);
   endtask

   task automatic permission_matrix();
      logic [VPN_DW-1:0] tag, p;
      tag = {TAG_HI'(15'h2a2a), SET_AW'(3)};
      p = VPN_DW'($urandom);
      write_word(OP_WR_LO, 0, 3, lo_entry(tag, 1'b1));
      for (int perm = 0; perm < 16; perm++)
      begin
         write_word(OP_WR_HI, 0, 3, hi_entry(p, {1'b0, 4'(perm)}));
         for (int mi = 0; mi < 2; mi++)
            for (int st = 0; st < 2; st++)
               lookup(tag, 1'(st), priv_mode_e'(1'(mi)), 1'b1);
      end
   endtask

   task automatic uncached_rules();
      logic [VPN_DW-1:0] tag, p;
      logic [3:0] sel;
      tag = {TAG_HI'(15'h0555), SET_AW'(9)};
      write_word(OP_WR_LO, 1, 9, lo_entry(tag, 1'b1));
      for (int i = 0; i < 16; i++)
      begin
         sel = 4'(i);
         p = VPN_DW'($urandom);
         p[VPN_DW-1] = sel[1];
         // Root read always allowed, root store never, user read by sel[2]
         write_word(OP_WR_HI, 1, 9, hi_entry(p, {sel[0], 1'b1, 1'b0, sel[2], sel[3]}));
         lookup(tag, 1'b0, MODE_ROOT, 1'b1);
         lookup(tag, 1'b0, MODE_USER, 1'b1);
         lookup(tag, 1'b1, MODE_ROOT, 1'b1);
      end
   endtask

   task automatic random_traffic();
      int w, s, kind;
      logic [VPN_DW-1:0] lk_vpn;
      tlb_lo_t e;
      msr_op_e op;
      logic [`DMMU_DW-1:0] data;
      // High words defined everywhere before any hit
      for (int wi = 0; wi < WAYS; wi++)
         for (int si = 0; si < SETS; si++)
            write_word(OP_WR_HI, wi, si, $urandom);
      repeat (200)
      begin
         kind = int'($urandom % 3);
         w = int'($urandom % 2);
         s = int'($urandom % SETS);
         lk_vpn = {TAG_HI'($urandom % 5), SET_AW'(s)};
         if (1'($urandom))
         begin
            op = OP_WR_LO;
            e = lo_entry({TAG_HI'($urandom % 4), SET_AW'(s)}, ($urandom % 4) != 0);
            // Tags stay unique across the ways of a set
            if (e.v && lo_sh[1-w][s].v && lo_sh[1-w][s].vpn == e.vpn)
               e.vpn[SET_AW] = ~e.vpn[SET_AW];
            data = e;
         end
         else
         begin
            op = OP_WR_HI;
            data = $urandom;
         end
         if (kind == 1)
            op = OP_NONE;
         drive_cycle(kind != 0, lk_vpn, 1'($urandom), priv_mode_e'(1'($urandom)),
            ($urandom % 4) != 0, op, {WAY_AW'(w), SET_AW'(s)}, data);
      end
   endtask

   initial
   begin
      void'($urandom(84569));
      for (int w = 0; w < WAYS; w++)
         for (int s = 0; s < SETS; s++)
         begin
            lo_sh[w][s] = '0;
            hi_sh[w][s] = '0;
         end
      reset <= 1'b1;
      re <= 1'b0;
      vpn <= '0;
      we <= 1'b0;
      mode <= MODE_USER;
      dmme <= 1'b0;
      tlb_op <= OP_NONE;
      tlb_idx <= '0;
      tlb_wdat <= '0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      // Reset values, zero VPN registered with translation off
      @(negedge clk);
      compare_outputs(expected_result('0, 1'b0, MODE_USER, 1'b0));
      identity_when_disabled();
      empty_tlb_misses();
      two_way_hits();
      permission_matrix();
      uncached_rules();
      random_traffic();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: src/dmmu_top.sv
// Data MMU top level
`timescale 1ns/1ns
`include "dmmu_consts.svh"

module dmmu_top
   import dmmu_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     reset,
   // Lookup request
   input  logic                                     re,
   input  logic [`DMMU_VPN_DW-1:0]                  vpn,
   input  logic                                     we,
   input  priv_mode_e                               mode,
   input  logic                                     dmme,
   // Software TLB fill
   input  msr_op_e                                  tlb_op,
   input  logic [`DMMU_WAY_AW+`DMMU_SET_AW-1:0]     tlb_idx,
   input  logic [`DMMU_DW-1:0]                      tlb_wdat,
   // Results, one cycle after re
   output logic [`DMMU_VPN_DW-1:0]                  ppn,
   output logic                                     edtm,
   output logic                                     edpf,
   output logic                                     uncached
);

   tlb_lookup_if lk ();

   logic                           acc_we_q;
   priv_mode_e                     mode_q;
   logic                           dmme_q;
   logic [`DMMU_VPN_DW-1:0]        tgt_vpn_q;
   logic [`DMMU_WAYS-1:0]          way_hit;
   tlb_hi_t [`DMMU_WAYS-1:0]       way_hi;

   dmmu_req_stage u_req
   (
      .clk       (clk),
      .reset     (reset),
      .re        (re),
      .vpn       (vpn),
      .we        (we),
      .mode      (mode),
      .dmme      (dmme),
      .tlb_op    (tlb_op),
      .tlb_idx   (tlb_idx),
      .tlb_wdat  (tlb_wdat),
      .lk        (lk.req),
      .acc_we_q  (acc_we_q),
      .mode_q    (mode_q),
      .dmme_q    (dmme_q),
      .tgt_vpn_q (tgt_vpn_q)
   );

   // Identical ways, each picks its own select bit
   for (genvar w = 0; w < `DMMU_WAYS; w++)
   begin : g_way
      dtlb_way #(.WAY_ID(w)) u_way
      (
         .clk     (clk),
         .reset   (reset),
         .lk      (lk.way),
         .hit     (way_hit[w]),
         .hi_word (way_hi[w])
      );
   end

   dmmu_resolve u_resolve
   (
      .clk       (clk),
      .way_hit   (way_hit),
      .way_hi    (way_hi),
      .acc_we_q  (acc_we_q),
      .mode_q    (mode_q),
      .dmme_q    (dmme_q),
      .tgt_vpn_q (tgt_vpn_q),
      .ppn       (ppn),
      .edtm      (edtm),
      .edpf      (edpf),
      .uncached  (uncached)
   );

endmodule

// File: src/dmmu_resolve.sv
// Data MMU result resolve
`timescale 1ns/1ns
`include "dmmu_consts.svh"

module dmmu_resolve
   import dmmu_pkg::*;
(
   input  logic                              clk,
   input  logic [`DMMU_WAYS-1:0]             way_hit,
   input  tlb_hi_t [`DMMU_WAYS-1:0]          way_hi,
   input  logic                              acc_we_q,
   input  priv_mode_e                        mode_q,
   input  logic                              dmme_q,
   input  logic [`DMMU_VPN_DW-1:0]           tgt_vpn_q,
   output logic [`DMMU_VPN_DW-1:0]           ppn,
   output logic                              edtm,
   output logic                              edpf,
   output logic                              uncached
);

   localparam int  VPN_DW     = `DMMU_VPN_DW;
   localparam bit  UNC_SEG_EN = (`DMMU_UNC_SEG == 1);

   tlb_hi_t   sel_hi;
   logic      miss;
   logic      perm_ok;
   logic      unc_entry;
   logic      unc_seg;

   // High word of the hitting way
   // Only one way hits so the OR yields its word
   always_comb
   begin
      sel_hi = '0;
      for (int w = 0; w < `DMMU_WAYS; w++)
      begin
         if (way_hit[w])
            sel_hi = sel_hi | way_hi[w];
      end
   end

   assign miss = ~|way_hit;

   // Permission bit picked by mode and access type
   always_comb
   begin
      case (mode_q)
         MODE_ROOT: perm_ok = acc_we_q ? sel_hi.rw : sel_hi.rr;
         default:   perm_ok = acc_we_q ? sel_hi.uw : sel_hi.ur;
      endcase
   end

   // Exceptions only with translation on
   assign edtm = miss & dmme_q;
   assign edpf = ~perm_ok & ~miss & dmme_q;

   // Identity mapping while translation is off
   assign ppn = dmme_q ? sel_hi.ppn : tgt_vpn_q;

   // Entry attribute counts only on a clean translated hit
   assign unc_entry = dmme_q & ~miss & perm_ok & sel_hi.unc;

   // Low half of physical space is uncached whether translated or not
   assign unc_seg = UNC_SEG_EN & ~edtm & ~edpf & ~ppn[VPN_DW-1];

   assign uncached = unc_entry | unc_seg;

   // Software must keep tags unique across the ways of a set
   a_hit_onehot: assert property (@(posedge clk) $onehot0(way_hit))
      else $error("multiple TLB ways hit: %b", way_hit);

endmodule

// File: src/dtlb_way.sv
// Data TLB way
`timescale 1ns/1ns
`include "dmmu_consts.svh"

module dtlb_way
   import dmmu_pkg::*;
#(
   parameter int WAY_ID = 0
)
(
   input  logic             clk,
   input  logic             reset,
   tlb_lookup_if.way        lk,
   output logic             hit,
   output tlb_hi_t          hi_word
);

   localparam int SETS = 1 << `DMMU_SET_AW;

   // Low word storage split into tag array and valid flags
   logic [`DMMU_VPN_DW-1:0]   tag_mem [SETS];
   logic [SETS-1:0]           valid_q;

   // High word storage
   tlb_hi_t                   hi_mem [SETS];

   // Registered read of the low word
   logic [`DMMU_VPN_DW-1:0]   rd_tag_q;
   logic                      rd_v_q;

   // Write strobes for this way
   logic                      wr_lo;
   logic                      wr_hi;
   tlb_lo_t                   wr_lo_word;

   assign wr_lo      = lk.wr_way_sel[WAY_ID] && (lk.wr_op == OP_WR_LO);
   assign wr_hi      = lk.wr_way_sel[WAY_ID] && (lk.wr_op == OP_WR_HI);
   assign wr_lo_word = tlb_lo_t'(lk.wr_data);

   // Valid flags and their read register
   // Nonblocking update keeps a same-edge lookup on the old entry
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_q <= '0;
         rd_v_q  <= 1'b0;
      end
      else
      begin
         if (wr_lo)
            valid_q[lk.wr_set] <= wr_lo_word.v;
         if (lk.rd_en)
            rd_v_q <= valid_q[lk.rd_set];
      end
   end

   // Tag and high word arrays
   always_ff @(posedge clk)
   begin
      if (wr_lo)
         tag_mem[lk.wr_set] <= wr_lo_word.vpn;
      if (wr_hi)
         hi_mem[lk.wr_set] <= tlb_hi_t'(lk.wr_data);
      if (lk.rd_en)
      begin
         rd_tag_q <= tag_mem[lk.rd_set];
         hi_word  <= hi_mem[lk.rd_set];
      end
   end

   // Compare against the VPN registered on the same strobe
   assign hit = rd_v_q && (rd_tag_q == lk.tgt_vpn);

   // A selected way takes exactly one entry word per cycle
   a_one_array: assert property (@(posedge clk) disable iff (reset)
      lk.wr_way_sel[WAY_ID] |-> (wr_lo ^ wr_hi))
      else $error("way %0d selected without a single target array", WAY_ID);

endmodule

// File: src/dmmu_req_stage.sv
// Data MMU request stage
`timescale 1ns/1ns
`include "dmmu_consts.svh"

module dmmu_req_stage
   import dmmu_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     re,
   input  logic [`DMMU_VPN_DW-1:0]                  vpn,
   input  logic                                     we,
   input  priv_mode_e                               mode,
   input  logic                                     dmme,
   input  msr_op_e                                  tlb_op,
   input  logic [`DMMU_WAY_AW+`DMMU_SET_AW-1:0]     tlb_idx,
   input  logic [`DMMU_DW-1:0]                      tlb_wdat,
   tlb_lookup_if.req                                lk,
   output logic                                     acc_we_q,
   output priv_mode_e                               mode_q,
   output logic                                     dmme_q,
   output logic [`DMMU_VPN_DW-1:0]                  tgt_vpn_q
);

   localparam int SET_AW = `DMMU_SET_AW;
   localparam int WAY_AW = `DMMU_WAY_AW;

   // Way field sits above the set field in the write index
   logic [WAY_AW-1:0]   wr_way;

   assign wr_way = tlb_idx[SET_AW +: WAY_AW];

   // Request registers, loaded only on a lookup strobe
   // Held between strobes so results stay stable
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         acc_we_q  <= 1'b0;
         mode_q    <= MODE_USER;
         dmme_q    <= 1'b0;
         tgt_vpn_q <= '0;
      end
      else if (re)
      begin
         acc_we_q  <= we;
         mode_q    <= mode;
         dmme_q    <= dmme;
         tgt_vpn_q <= vpn;
      end
   end

   // Set index comes straight from the low VPN bits
   // so the way arrays read in the strobe cycle
   assign lk.rd_en   = re;
   assign lk.rd_set  = vpn[SET_AW-1:0];
   assign lk.tgt_vpn = tgt_vpn_q;

   // Fill command passes through unregistered
   assign lk.wr_op   = tlb_op;
   assign lk.wr_set  = tlb_idx[SET_AW-1:0];
   assign lk.wr_data = tlb_wdat;

   // One-hot way select, empty when no write is pending
   always_comb
   begin
      for (int w = 0; w < `DMMU_WAYS; w++)
      begin
         lk.wr_way_sel[w] = (tlb_op != OP_NONE) && (wr_way == WAY_AW'(w));
      end
   end

   // Software may only issue the defined fill opcodes
   a_op_legal: assert property (@(posedge clk) disable iff (reset)
      tlb_op inside {OP_NONE, OP_WR_LO, OP_WR_HI})
      else $error("illegal TLB write opcode %0d", tlb_op);

endmodule

// File: src/tlb_lookup_if.sv
// TLB lookup and fill bus
`timescale 1ns/1ns
`include "dmmu_consts.svh"

interface tlb_lookup_if
   import dmmu_pkg::*;
();

   // Lookup side
   logic                        rd_en;
   logic [`DMMU_SET_AW-1:0]     rd_set;
   logic [`DMMU_VPN_DW-1:0]     tgt_vpn;

   // Software fill side
   msr_op_e                     wr_op;
   logic [`DMMU_WAYS-1:0]       wr_way_sel;
   logic [`DMMU_SET_AW-1:0]     wr_set;
   logic [`DMMU_DW-1:0]         wr_data;

   // Request stage drives everything
   modport req
   (
      output rd_en, rd_set, tgt_vpn,
      output wr_op, wr_way_sel, wr_set, wr_data
   );

   // Each way only listens
   modport way
   (
      input rd_en, rd_set, tgt_vpn,
      input wr_op, wr_way_sel, wr_set, wr_data
   );

endinterface

// File: src/dmmu_pkg.sv
// Data MMU types
`include "dmmu_consts.svh"

package dmmu_pkg;

   // Software write command, names the entry word
   typedef enum logic [1:0]
   {
      OP_NONE  = 2'd0,
      OP_WR_LO = 2'd1,
      OP_WR_HI = 2'd2
   } msr_op_e;

   // Privilege of the access
   typedef enum logic
   {
      MODE_USER = 1'b0,
      MODE_ROOT = 1'b1
   } priv_mode_e;

   // Low entry word, tag on top and valid in bit 0
   typedef struct packed
   {
      logic [`DMMU_VPN_DW-1:0]                vpn;
      logic [`DMMU_DW-`DMMU_VPN_DW-2:0]       rsvd;
      logic                                   v;
   } tlb_lo_t;

   // High entry word, PPN on top and attribute bits below
   typedef struct packed
   {
      logic [`DMMU_VPN_DW-1:0]                ppn;
      logic [`DMMU_DW-`DMMU_VPN_DW-9:0]       rsvd_hi;
      logic                                   unc;
      logic                                   rr;
      logic                                   rw;
      logic                                   ur;
      logic                                   uw;
      logic [2:0]                             rsvd_lo;
   } tlb_hi_t;

endpackage

// File: include/dmmu_consts.svh
// Data MMU constants
`ifndef DMMU_CONSTS_SVH
`define DMMU_CONSTS_SVH

// Virtual and physical address width
`define DMMU_AW 32

// Width of one TLB entry word
`define DMMU_DW 32

// Page offset bits, 8 KB pages
`define DMMU_PAGE_SHIFT 13

// Page number width, same for VPN and PPN
`define DMMU_VPN_DW (`DMMU_AW - `DMMU_PAGE_SHIFT)

// Set index bits, 16 sets per way
`define DMMU_SET_AW 4

// Associativity
`define DMMU_WAYS 2

// Way select bits at the top of a write index
`define DMMU_WAY_AW 1

// Set to 1 for an uncached low half of physical memory
`define DMMU_UNC_SEG 1

`endif
